/* dcache_block_mover.sv */
// Two-word memory transfer sequencer for victim writeback and block refill
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_block_mover (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          start_i,
    input  logic                          write_i,
    input  logic [`DCACHE_ADDR_W-1:0]     base_addr_i,
    input  dcache_pkg::frame_t            wb_frame_i,
    output dcache_pkg::mem_req_t          mem_req_o,
    input  logic                          mem_wait_i,
    input  dcache_pkg::word_t             mem_rdata_i,
    output logic                          word_done_o,
    output logic [`DCACHE_WORD_OFF_W-1:0] word_sel_o,
    output dcache_pkg::word_t             fill_data_o,
    output logic                          block_done_o
);
    import dcache_pkg::*;

    logic                          busy_q;
    logic                          write_q;
    logic [`DCACHE_WORD_OFF_W-1:0] cnt_q;
    logic [`DCACHE_ADDR_W-1:0]     base_q;

    assign word_done_o  = busy_q & ~mem_wait_i;
    assign block_done_o = word_done_o & (cnt_q == {`DCACHE_WORD_OFF_W{1'b1}});
    assign word_sel_o   = cnt_q;
    assign fill_data_o  = mem_rdata_i;

    // Strobes hold while memory waits
    assign mem_req_o = '{
        ren:   busy_q & ~write_q,
        wen:   busy_q & write_q,
        addr:  {base_q[`DCACHE_ADDR_W-1:`DCACHE_WORD_OFF_W+`DCACHE_BYTE_OFF_W], cnt_q,
                {`DCACHE_BYTE_OFF_W{1'b0}}},
        wdata: wb_frame_i.data[cnt_q]
    };

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end
        else if (start_i) begin  // May restart on the block_done cycle
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end
        else if (block_done_o) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end
        else if (word_done_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (start_i) begin
            write_q <= write_i;
            base_q  <= base_addr_i;
        end
    end

    a_hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
        ((mem_req_o.ren || mem_req_o.wen) && mem_wait_i) |=>
            $stable({mem_req_o.ren, mem_req_o.wen, mem_req_o.addr}))
        else $error("memory request changed during a wait at addr %h", mem_req_o.addr);

endmodule

/* dcache_config.svh */
// Width, set count and block size macros for the data cache
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

`define DCACHE_ADDR_W       32
`define DCACHE_WORD_W       32

`define DCACHE_SETS         8
`define DCACHE_INDEX_W      3
`define DCACHE_TAG_W        26

`define DCACHE_BLOCK_WORDS  2
`define DCACHE_WORD_OFF_W   1   // log2 of block words
`define DCACHE_BYTE_OFF_W   2

`endif

/* dcache_controller.sv */
// Cache FSM ordering hits, victim writeback, refill and halt flush
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_controller (
    input  logic                      CLK,
    input  logic                      nRST,
    input  dcache_pkg::cpu_req_t      cpu_req_i,
    input  logic                      halt_i,
    output dcache_pkg::cpu_rsp_t      cpu_rsp_o,
    output dcache_pkg::addr_fields_t  store_addr_o,
    input  dcache_pkg::lookup_t       lookup_i,
    input  dcache_pkg::victim_t       victim_i,
    output logic                      hit_write_o,
    output logic                      set_dirty_o,
    output logic                      fill_word_o,
    output logic                      fill_way_o,
    output logic                      invalidate_o,
    output logic                      touch_o,
    output logic                      mv_start_o,
    output logic                      mv_write_o,
    output logic [`DCACHE_ADDR_W-1:0] mv_base_o,
    output dcache_pkg::frame_t        mv_frame_o,
    input  logic                      word_done_i,
    input  logic                      block_done_i,
    output logic                      scan_step_o,
    input  logic                      scan_dirty_i,
    input  logic [`DCACHE_ADDR_W-1:0] scan_addr_i,
    input  logic                      scan_way_i,
    input  logic                      scan_done_i
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE, WRITEBACK, REFILL, FLUSH_CHECK, FLUSH_WB, DONE
    } state_e;

    state_e                    state_q, state_d;
    addr_fields_t              cpu_addr;
    logic [`DCACHE_ADDR_W-1:0] refill_base;
    logic                      access;
    logic                      flushing;
    logic                      dhit;

    assign cpu_addr = addr_fields_t'(cpu_req_i.addr);
    assign access   = cpu_req_i.ren | cpu_req_i.wen;
    assign flushing = (state_q == FLUSH_CHECK) || (state_q == FLUSH_WB);
    assign refill_base = {cpu_addr.tag, cpu_addr.index,
                          {(`DCACHE_WORD_OFF_W + `DCACHE_BYTE_OFF_W){1'b0}}};

    // Flush reads the scanned frame back through the lookup port
    assign store_addr_o = flushing ? addr_fields_t'(scan_addr_i) : cpu_addr;
    assign mv_frame_o   = lookup_i.entry.way[flushing ? scan_way_i : victim_i.way];
    assign fill_way_o   = victim_i.way;

    assign cpu_rsp_o = '{
        dhit:    dhit,
        load:    lookup_i.entry.way[lookup_i.way].data[cpu_addr.word_off],
        flushed: state_q == DONE
    };

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
        end
        else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        dhit         = 1'b0;
        hit_write_o  = 1'b0;
        set_dirty_o  = 1'b0;
        fill_word_o  = 1'b0;
        invalidate_o = 1'b0;
        touch_o      = 1'b0;
        mv_start_o   = 1'b0;
        mv_write_o   = 1'b0;
        mv_base_o    = refill_base;
        scan_step_o  = 1'b0;
        case (state_q)
            IDLE: begin
                if (halt_i) begin
                    state_d = FLUSH_CHECK;
                end
                else if (access && lookup_i.hit) begin
                    dhit        = 1'b1;
                    touch_o     = 1'b1;
                    hit_write_o = cpu_req_i.wen;
                    set_dirty_o = cpu_req_i.wen;
                end
                else if (access) begin
                    mv_start_o = 1'b1;
                    if (victim_i.dirty) begin
                        mv_write_o = 1'b1;
                        mv_base_o  = victim_i.base_addr;
                        state_d    = WRITEBACK;
                    end
                    else begin
                        state_d = REFILL;
                    end
                end
            end
            WRITEBACK: begin
                if (block_done_i) begin  // Drop victim, refill right away
                    invalidate_o = 1'b1;
                    mv_start_o   = 1'b1;
                    state_d      = REFILL;
                end
            end
            REFILL: begin
                fill_word_o = word_done_i;
                set_dirty_o = cpu_req_i.wen & word_done_i;  // Write miss allocates dirty
                if (block_done_i) begin
                    state_d = IDLE;  // Request then hits
                end
            end
            FLUSH_CHECK: begin
                if (scan_done_i) begin
                    state_d = DONE;
                end
                else if (scan_dirty_i) begin
                    mv_start_o = 1'b1;
                    mv_write_o = 1'b1;
                    mv_base_o  = scan_addr_i;
                    state_d    = FLUSH_WB;
                end
                else begin
                    scan_step_o = 1'b1;
                end
            end
            FLUSH_WB: begin
                if (block_done_i) begin
                    scan_step_o = 1'b1;
                    state_d     = FLUSH_CHECK;
                end
            end
            DONE: begin
                state_d = DONE;  // Held until reset
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Mover may only complete words while a transfer state waits for it
    a_mover_in_transfer: assert property (@(posedge CLK) disable iff (!nRST)
        word_done_i |-> (state_q == WRITEBACK || state_q == REFILL || state_q == FLUSH_WB))
        else $error("block mover busy outside a transfer, flushed %b", cpu_rsp_o.flushed);

endmodule

/* dcache_flush_scan.sv */
// Frame walker that reports dirty frames during halt
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_flush_scan (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      step_i,
    output logic [`DCACHE_INDEX_W:0]  scan_index_o,
    input  dcache_pkg::frame_t        scan_frame_i,
    output logic                      dirty_o,
    output logic [`DCACHE_ADDR_W-1:0] frame_addr_o,
    output logic                      way_o,
    output logic                      all_done_o
);

    // Set in low bits, way above, so left ways come first
    logic [`DCACHE_INDEX_W+1:0] cnt_q;

    assign scan_index_o = cnt_q[`DCACHE_INDEX_W:0];
    assign way_o        = cnt_q[`DCACHE_INDEX_W];
    assign all_done_o   = cnt_q[`DCACHE_INDEX_W+1];  // Past frame sixteen

    assign dirty_o = ~all_done_o & scan_frame_i.valid & scan_frame_i.dirty;

    assign frame_addr_o = {scan_frame_i.tag, cnt_q[`DCACHE_INDEX_W-1:0],
                           {(`DCACHE_WORD_OFF_W + `DCACHE_BYTE_OFF_W){1'b0}}};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt_q <= '0;
        end
        else if (step_i && !all_done_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

/* dcache_frame_store.sv */
// Two-way set array with tag compare, victim select, LRU and frame updates
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_frame_store (
    input  logic                              CLK,
    input  logic                              nRST,
    input  dcache_pkg::addr_fields_t          addr_i,
    output dcache_pkg::lookup_t               lookup_o,
    output dcache_pkg::victim_t               victim_o,
    input  logic                              hit_write_i,
    input  dcache_pkg::word_t                 wdata_i,
    input  logic                              set_dirty_i,
    input  logic                              fill_word_i,
    input  logic                              fill_way_i,
    input  logic [`DCACHE_WORD_OFF_W-1:0]     word_sel_i,
    input  dcache_pkg::word_t                 fill_data_i,
    input  logic                              invalidate_i,
    input  logic                              touch_i,
    input  logic [`DCACHE_INDEX_W:0]          scan_index_i,
    output dcache_pkg::frame_t                scan_frame_o
);
    import dcache_pkg::*;

    set_t   sets_q [`DCACHE_SETS];
    set_t   cur;
    logic   hit0, hit1;
    logic   hit_way;
    logic   vway;
    frame_t vframe;

    assign cur  = sets_q[addr_i.index];
    assign hit0 = cur.way[0].valid && (cur.way[0].tag == addr_i.tag);
    assign hit1 = cur.way[1].valid && (cur.way[1].tag == addr_i.tag);
    assign hit_way = hit1;

    assign lookup_o = '{hit: hit0 | hit1, way: hit_way, entry: cur};

    assign vway   = ~cur.mru;  // Least recently used way
    assign vframe = cur.way[vway];
    assign victim_o = '{
        way:       vway,
        dirty:     vframe.valid & vframe.dirty,
        base_addr: {vframe.tag, addr_i.index,
                    {(`DCACHE_WORD_OFF_W + `DCACHE_BYTE_OFF_W){1'b0}}}
    };

    assign scan_frame_o =
        sets_q[scan_index_i[`DCACHE_INDEX_W-1:0]].way[scan_index_i[`DCACHE_INDEX_W]];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                sets_q[s].way[0].valid <= 1'b0;
                sets_q[s].way[0].dirty <= 1'b0;
                sets_q[s].way[1].valid <= 1'b0;
                sets_q[s].way[1].dirty <= 1'b0;
                sets_q[s].mru          <= 1'b0;
            end
        end
        else begin
            if (hit_write_i) begin
                sets_q[addr_i.index].way[hit_way].data[addr_i.word_off] <= wdata_i;
            end
            if (set_dirty_i && (hit0 || hit1)) begin
                sets_q[addr_i.index].way[hit_way].dirty <= 1'b1;  // Clean to dirty, no bus
            end
            if (touch_i) begin
                sets_q[addr_i.index].mru <= hit_way;
            end
            if (invalidate_i) begin
                sets_q[addr_i.index].way[fill_way_i].valid <= 1'b0;
            end
            if (fill_word_i) begin
                sets_q[addr_i.index].way[fill_way_i].data[word_sel_i] <= fill_data_i;
                if (word_sel_i == {`DCACHE_WORD_OFF_W{1'b1}}) begin  // Last word
                    sets_q[addr_i.index].way[fill_way_i].valid <= 1'b1;
                    sets_q[addr_i.index].way[fill_way_i].tag   <= addr_i.tag;
                    sets_q[addr_i.index].way[fill_way_i].dirty <= set_dirty_i;
                end
            end
        end
    end

    for (genvar s = 0; s < `DCACHE_SETS; s++) begin : g_tag_check
        a_unique_tag: assert property (@(posedge CLK) disable iff (!nRST)
            !(sets_q[s].way[0].valid && sets_q[s].way[1].valid &&
              sets_q[s].way[0].tag == sets_q[s].way[1].tag))
            else $error("set %0d holds tag %h in both ways", s, sets_q[s].way[0].tag);
    end

endmodule

/* dcache_pkg.sv */
// Address, frame, set, request and response types of the data cache
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]      tag;
        logic [`DCACHE_INDEX_W-1:0]    index;
        logic [`DCACHE_WORD_OFF_W-1:0] word_off;
        logic [`DCACHE_BYTE_OFF_W-1:0] byte_off;
    } addr_fields_t;

    typedef struct packed {
        logic                            valid;
        logic                            dirty;
        logic [`DCACHE_TAG_W-1:0]        tag;
        word_t [`DCACHE_BLOCK_WORDS-1:0] data;
    } frame_t;

    typedef struct packed {
        frame_t [1:0] way;
        logic         mru;  // Way used last, victim is the other
    } set_t;

    typedef struct packed {
        logic                      ren;
        logic                      wen;
        logic [`DCACHE_ADDR_W-1:0] addr;
        word_t                     wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  dhit;
        word_t load;
        logic  flushed;
    } cpu_rsp_t;

    typedef struct packed {
        logic                      ren;
        logic                      wen;
        logic [`DCACHE_ADDR_W-1:0] addr;
        word_t                     wdata;
    } mem_req_t;

    typedef struct packed {
        logic hit;
        logic way;
        set_t entry;
    } lookup_t;

    typedef struct packed {
        logic                      way;
        logic                      dirty;      // Valid and dirty, needs writeback
        logic [`DCACHE_ADDR_W-1:0] base_addr;
    } victim_t;

endpackage

/* dcache_top.sv */
// Top level of the data cache with controller, frame store, mover and flush scan
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
    input  logic                 CLK,
    input  logic                 nRST,
    input  dcache_pkg::cpu_req_t cpu_req_i,
    input  logic                 halt_i,
    output dcache_pkg::cpu_rsp_t cpu_rsp_o,
    output dcache_pkg::mem_req_t mem_req_o,
    input  logic                 mem_wait_i,
    input  dcache_pkg::word_t    mem_rdata_i
);
    import dcache_pkg::*;

    addr_fields_t                  store_addr;
    lookup_t                       lookup;
    victim_t                       victim;
    frame_t                        mv_frame, scan_frame;
    word_t                         fill_data;
    logic [`DCACHE_ADDR_W-1:0]     mv_base, scan_addr;
    logic [`DCACHE_WORD_OFF_W-1:0] word_sel;
    logic [`DCACHE_INDEX_W:0]      scan_index;
    logic hit_write, set_dirty, fill_word, fill_way, invalidate, touch;
    logic mv_start, mv_write, word_done, block_done;
    logic scan_step, scan_dirty, scan_way, scan_done;

    dcache_controller i_controller (
        .CLK, .nRST, .cpu_req_i, .halt_i, .cpu_rsp_o,
        .store_addr_o(store_addr), .lookup_i(lookup), .victim_i(victim),
        .hit_write_o(hit_write), .set_dirty_o(set_dirty), .fill_word_o(fill_word),
        .fill_way_o(fill_way), .invalidate_o(invalidate), .touch_o(touch),
        .mv_start_o(mv_start), .mv_write_o(mv_write), .mv_base_o(mv_base),
        .mv_frame_o(mv_frame), .word_done_i(word_done), .block_done_i(block_done),
        .scan_step_o(scan_step), .scan_dirty_i(scan_dirty), .scan_addr_i(scan_addr),
        .scan_way_i(scan_way), .scan_done_i(scan_done)
    );

    dcache_frame_store i_store (
        .CLK, .nRST, .addr_i(store_addr), .lookup_o(lookup), .victim_o(victim),
        .hit_write_i(hit_write), .wdata_i(cpu_req_i.wdata), .set_dirty_i(set_dirty),
        .fill_word_i(fill_word), .fill_way_i(fill_way), .word_sel_i(word_sel),
        .fill_data_i(fill_data), .invalidate_i(invalidate), .touch_i(touch),
        .scan_index_i(scan_index), .scan_frame_o(scan_frame)
    );

    dcache_block_mover i_mover (
        .CLK, .nRST, .start_i(mv_start), .write_i(mv_write), .base_addr_i(mv_base),
        .wb_frame_i(mv_frame), .mem_req_o, .mem_wait_i, .mem_rdata_i,
        .word_done_o(word_done), .word_sel_o(word_sel), .fill_data_o(fill_data),
        .block_done_o(block_done)
    );

    dcache_flush_scan i_scan (
        .CLK, .nRST, .step_i(scan_step), .scan_index_o(scan_index),
        .scan_frame_i(scan_frame), .dirty_o(scan_dirty), .frame_addr_o(scan_addr),
        .way_o(scan_way), .all_done_o(scan_done)
    );

endmodule

/* sources.f */
dcache_pkg.sv
dcache_frame_store.sv
dcache_block_mover.sv
dcache_flush_scan.sv
dcache_controller.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv
+incdir+.

/* tb_dcache.sv */
// Testbench top with clock, reset, stimulus, LRU model, assertions and watchdog
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int N_RAND    = 60;
    localparam int N_ACCESS  = 16 + N_RAND;
    localparam int MAX_WAIT  = 2;   // A wait cycle is never followed by another
    localparam int LIMIT_CYC = N_ACCESS * 20 * MAX_WAIT + 16 * 2 * 20 * MAX_WAIT + 100;

    logic     CLK, nRST, halt, mem_wait, waits_on;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    word_t    mem_rdata;
    logic [15:0] wait_lfsr, data_lfsr;

    // Reference of processor stores
    word_t ref_mem [1024];
    logic  stored [1024];

    // LRU model of the cache
    logic        m_valid [8][2];
    logic        m_dirty [8][2];
    logic [25:0] m_tag   [8][2];
    logic        m_mru   [8];

    logic        exp_hit, exp_miss, wb_due;
    logic [31:0] wb_base;
    int          assert_errs, shadow_errs;

    dcache_top i_dcache_top (
        .CLK, .nRST, .cpu_req_i(cpu_req), .halt_i(halt), .cpu_rsp_o(cpu_rsp),
        .mem_req_o(mem_req), .mem_wait_i(mem_wait), .mem_rdata_i(mem_rdata)
    );

    tb_mem_model i_mem (
        .CLK, .mem_req_i(mem_req), .mem_wait_i(mem_wait), .rdata_o(mem_rdata)
    );

    always #50 CLK = ~CLK;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic word_t expected_word(input logic [31:0] addr);
        if (stored[addr[11:2]]) begin
            return ref_mem[addr[11:2]];
        end
        return addr ^ 32'hA5A5A5A5;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            val = {val[30:0], data_lfsr[0]};
        end
    endtask

    // Wait states, at most one cycle in a row
    always @(posedge CLK) begin
        #5;
        wait_lfsr = lfsr_next(wait_lfsr);
        mem_wait  = waits_on && wait_lfsr[0] && !mem_wait;
    end

    task automatic access(input logic wr, input logic [31:0] addr, input word_t data);
        logic [2:0]  idx;
        logic [25:0] tag;
        logic        hit;
        logic        way;
        idx = addr[5:3];
        tag = addr[31:6];
        hit = 1'b0;
        way = ~m_mru[idx];
        for (int w = 0; w < 2; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        wb_due   = !hit && m_valid[idx][way] && m_dirty[idx][way];
        wb_base  = {m_tag[idx][way], idx, 3'b000};
        exp_hit  = hit;
        exp_miss = !hit;
        cpu_req  = '{ren: !wr, wen: wr, addr: addr, wdata: data};
        @(negedge CLK);
        if (!cpu_rsp.dhit) begin
            @(posedge CLK);
            #5;
            exp_hit  = 1'b0;
            exp_miss = 1'b0;
            while (!cpu_rsp.dhit) @(negedge CLK);
        end
        @(posedge CLK);
        #5;
        if (wr) begin
            ref_mem[addr[11:2]] = data;
            stored[addr[11:2]]  = 1'b1;
        end
        cpu_req  = '0;
        exp_hit  = 1'b0;
        exp_miss = 1'b0;
        wb_due   = 1'b0;
        m_valid[idx][way] = 1'b1;
        m_tag[idx][way]   = tag;
        m_dirty[idx][way] = hit ? (m_dirty[idx][way] | wr) : wr;
        m_mru[idx]        = way;
    endtask

    a_load_value: assert property (@(posedge CLK) disable iff (!nRST)
        (cpu_rsp.dhit && cpu_req.ren) |-> cpu_rsp.load == expected_word(cpu_req.addr))
        else begin
            assert_errs++;
            $display("** Error: cpu_rsp.load = %h, expected %h at %h", $sampled(cpu_rsp.load),
                     expected_word($sampled(cpu_req.addr)), $sampled(cpu_req.addr));
        end

    a_hit_now: assert property (@(posedge CLK) disable iff (!nRST) exp_hit |-> cpu_rsp.dhit)
        else begin
            assert_errs++;
            $display("** Error: cpu_rsp.dhit = 0, expected 1 at %h", $sampled(cpu_req.addr));
        end

    a_miss_now: assert property (@(posedge CLK) disable iff (!nRST) exp_miss |-> !cpu_rsp.dhit)
        else begin
            assert_errs++;
            $display("** Error: cpu_rsp.dhit = 1, expected 0 at %h", $sampled(cpu_req.addr));
        end

    a_victim_addr: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.wen && !halt) |-> (wb_due && mem_req.addr[31:3] == wb_base[31:3]))
        else begin
            assert_errs++;
            $display("** Error: mem_req.addr = %h, expected victim base %h (due %h)",
                     $sampled(mem_req.addr), $sampled(wb_base), $sampled(wb_due));
        end

    a_wb_data: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.wen && !mem_wait) |-> mem_req.wdata == expected_word(mem_req.addr))
        else begin
            assert_errs++;
            $display("** Error: mem_req.wdata = %h, expected %h at %h", $sampled(mem_req.wdata),
                     expected_word($sampled(mem_req.addr)), $sampled(mem_req.addr));
        end

    a_mem_range: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) |-> mem_req.addr < 32'h1000)
        else begin
            assert_errs++;
            $display("Memory access outside the modeled range at %h", $sampled(mem_req.addr));
        end

    initial begin
        #(100.0 * LIMIT_CYC);
        $display("Watchdog expired before the flush completed");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] r_op, r_addr, r_data;
        CLK = 1'b0;
        nRST = 1'b0;
        halt = 1'b0;
        mem_wait = 1'b0;
        waits_on = 1'b0;
        cpu_req = '0;
        exp_hit = 1'b0;
        exp_miss = 1'b0;
        wb_due = 1'b0;
        wb_base = '0;
        assert_errs = 0;
        shadow_errs = 0;
        wait_lfsr = 16'd37903;
        data_lfsr = 16'd37903;
        for (int i = 0; i < 1024; i++) begin
            stored[i]  = 1'b0;
            ref_mem[i] = '0;
        end
        for (int s = 0; s < 8; s++) begin
            m_mru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (10) @(posedge CLK);
        #5 nRST = 1'b1;
        @(posedge CLK);
        #5;

        access(1'b0, 32'h040, '0);  // Read miss, then other word hits
        access(1'b0, 32'h044, '0);
        access(1'b0, 32'h108, '0);  // Write hit on a clean frame
        access(1'b1, 32'h108, 32'hCAFE0108);
        access(1'b0, 32'h108, '0);
        access(1'b1, 32'h14C, 32'hBEEF014C);  // Write miss allocates
        access(1'b0, 32'h14C, '0);
        access(1'b1, 32'h010, 32'h11110010);  // Third tag evicts LRU dirty block
        access(1'b1, 32'h050, 32'h22220050);
        access(1'b0, 32'h090, '0);
        access(1'b1, 32'h018, 32'h33330018);  // A, B, A, then C evicts B
        access(1'b1, 32'h058, 32'h44440058);
        access(1'b0, 32'h018, '0);
        access(1'b0, 32'h098, '0);
        access(1'b0, 32'h018, '0);
        access(1'b0, 32'h05C, '0);

        waits_on = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            rand_bits(1, r_op);
            rand_bits(10, r_addr);
            rand_bits(32, r_data);
            access(r_op[0], {20'd0, r_addr[9:0], 2'b00}, r_data);
        end

        halt = 1'b1;
        while (!cpu_rsp.flushed) @(negedge CLK);
        for (int i = 0; i < 1024; i++) begin
            if (stored[i] && (!i_mem.written[i] || i_mem.shadow[i] !== ref_mem[i])) begin
                shadow_errs++;
                $display("** Error: shadow[%h] = %h, expected %h", i * 4, i_mem.shadow[i],
                         ref_mem[i]);
            end
        end
        $display("Errors: %0d assertion, %0d memory shadow", assert_errs, shadow_errs);
        if (assert_errs == 0 && shadow_errs == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tb_mem_model.sv */
// Testbench memory with address-rule read data and a shadow of written words
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_mem_model (
    input  logic                 CLK,
    input  dcache_pkg::mem_req_t mem_req_i,
    input  logic                 mem_wait_i,
    output dcache_pkg::word_t    rdata_o
);
    import dcache_pkg::*;

    localparam int WORDS = 1024;  // Test addresses stay below 4 KiB

    word_t shadow [WORDS];
    logic  written [WORDS];
    logic [9:0] widx;

    assign widx = mem_req_i.addr[11:2];

    // Data only on a read, unwritten words follow the address rule
    assign rdata_o = !mem_req_i.ren ? 'x :
                     written[widx]  ? shadow[widx] : (mem_req_i.addr ^ 32'hA5A5A5A5);

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            written[i] = 1'b0;
            shadow[i]  = '0;
        end
    end

    always @(posedge CLK) begin
        if (mem_req_i.wen && !mem_wait_i) begin
            shadow[widx]  <= mem_req_i.wdata;
            written[widx] <= 1'b1;
        end
    end

endmodule
